/* verilog.f */
verilog/acore_pkg.sv
verilog/frame_sequencer.sv
verilog/step_table.sv
verilog/emu_slice.sv
verilog/analog_core_emu.sv
bench/clk_gen.sv
bench/tb_analog_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_analog_core
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_analog_core.sv */
`timescale 1ns/1ps

module tb_analog_core;

    localparam int chunk_width = 4;
    localparam int num_chunks  = 4;
    localparam int nti         = 4;
    localparam int out_shift   = 2;
    localparam int clk_period  = 100;

    localparam int frame_len  = num_chunks + 2;
    localparam int hist_w     = num_chunks * chunk_width;
    localparam int bank_depth = num_chunks * (2 ** chunk_width);
    localparam int mag_max    = (2 ** acore_pkg::mag_width) - 1;
    localparam int conv_runs  = 30;

    // sample clock level for each counter value of a frame
    localparam logic [0:frame_len-1] clk_pattern = 6'b110001;

    // a table load writes one word per cycle while frames keep running
    localparam int table_frames = (nti * bank_depth) / frame_len + 2;
    localparam int bank_frames  = bank_depth / frame_len + 2;
    localparam int total_frames = 2 + (table_frames + num_chunks + 2)
                                  + (table_frames + 1 + conv_runs) + (bank_frames + 9)
                                  + (table_frames + num_chunks + 3);
    localparam int watchdog_ns  = (total_frames + 20) * frame_len * clk_period;

    logic                             emu_clk;
    logic                             emu_rst;
    logic [nti-1:0]                   rx_bits_i;
    acore_pkg::chan_wr_t              chan_wr_i;
    logic                             clk_adc_o;
    acore_pkg::adc_sample_t [nti-1:0] samples_o;

    int                tbl [nti][bank_depth];  // model of the step table
    logic [hist_w-1:0] hist_m;
    logic [hist_w-1:0] hist_prev;              // history of the frame that just ended
    int                frame_pos;
    logic [31:0]       lfsr_state;

    clk_gen #(
        .period_ns    (clk_period),
        .reset_cycles (3)
    ) i_clk_gen (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst)
    );

    analog_core_emu #(
        .chunk_width (chunk_width),
        .num_chunks  (num_chunks),
        .nti         (nti),
        .out_shift   (out_shift)
    ) i_analog_core_emu (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .rx_bits_i (rx_bits_i),
        .chan_wr_i (chan_wr_i),
        .clk_adc_o (clk_adc_o),
        .samples_o (samples_o)
    );

    // frame position and bit history with the newest bits entering at the top
    always @(posedge emu_clk) begin
        if (emu_rst) begin
            frame_pos <= 0;
            hist_m    <= '0;
            hist_prev <= '0;
        end else if (frame_pos == frame_len - 1) begin
            frame_pos <= 0;
            hist_prev <= hist_m;
            hist_m    <= {rx_bits_i, hist_m[hist_w-1:nti]};
        end else begin
            frame_pos <= frame_pos + 1;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // small signed words so that sums mix saturated and unsaturated results
    function automatic int rand_word();
        logic signed [9:0] w;
        w = 10'(rand_bits(10));
        return int'(w);
    endfunction

    function automatic acore_pkg::adc_sample_t expected_sample(input int s,
                                                               input logic [hist_w-1:0] hist);
        acore_pkg::adc_sample_t res;
        int sum;
        int mag;
        int chunk;
        sum = 0;
        for (int k = 0; k < num_chunks; k++) begin
            // chunk 0 sits at the top of the history
            chunk = int'(hist >> ((num_chunks - 1 - k) * chunk_width)) % (2 ** chunk_width);
            sum += tbl[s][k * (2 ** chunk_width) + chunk];
        end
        mag      = ((sum < 0) ? -sum : sum) >> out_shift;
        res.sign = (sum < 0);
        res.mag  = (mag > mag_max) ? acore_pkg::mag_width'(mag_max) : acore_pkg::mag_width'(mag);
        return res;
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int s,
                               input acore_pkg::adc_sample_t exp_s);
        assert (samples_o[s] === exp_s) else begin
            $display("Error: %s slice %0d expected sign %0d mag %0d, actual sign %0d mag %0d",
                     name, s, exp_s.sign, exp_s.mag, samples_o[s].sign, samples_o[s].mag);
            abort_run();
        end
    endtask

    task automatic check_samples(input string name);
        for (int s = 0; s < nti; s++) begin
            check_value(name, s, expected_sample(s, hist_prev));
        end
    endtask

    // returns 5 ns after the next last_cycle edge
    task automatic wait_frame_end();
        do begin
            @(posedge emu_clk);
            #5;
        end while (frame_pos != 0);
    endtask

    task automatic run_frame(input logic [nti-1:0] bits, input bit check, input string name);
        rx_bits_i = bits;  // held for the whole frame
        wait_frame_end();
        if (check) begin
            check_samples(name);
        end
    endtask

    task automatic write_word(input int bank, input int offs, input int data);
        chan_wr_i.we    = 1'b1;
        chan_wr_i.waddr = acore_pkg::chan_addr_width'(bank * bank_depth + offs);
        chan_wr_i.wdata = acore_pkg::step_width'(data);
        tbl[bank][offs] = data;
        @(posedge emu_clk);
        #5;
        chan_wr_i.we = 1'b0;
    endtask

    task automatic load_table();
        for (int b = 0; b < nti; b++) begin
            for (int a = 0; a < bank_depth; a++) begin
                write_word(b, a, tbl[b][a]);
            end
        end
    endtask

    task automatic test_reset_state();
        logic clk_exp;
        for (int s = 0; s < nti; s++) begin
            check_value("reset_state", s, '0);
        end
        for (int c = 0; c < 2 * frame_len; c++) begin
            // registered so it shows the level of the counter one cycle before
            clk_exp = clk_pattern[(frame_pos + frame_len - 1) % frame_len];
            assert (clk_adc_o === clk_exp) else begin
                $display("Error: reset_state cycle %0d expected clk_adc %0b, actual %0b",
                         c, clk_exp, clk_adc_o);
                abort_run();
            end
            @(posedge emu_clk);
            #5;
        end
    endtask

    task automatic test_single_chunk();
        for (int b = 0; b < nti; b++) begin
            for (int a = 0; a < bank_depth; a++) begin
                tbl[b][a] = 0;
            end
            tbl[b][(2 ** chunk_width) - 1] = (b - 1) * 300 + 44;  // chunk_idx 0 with all ones
        end
        load_table();
        for (int f = 0; f < num_chunks; f++) begin
            run_frame('0, f > 0, "single_chunk");
        end
        run_frame('1, 1'b1, "single_chunk");
        run_frame('0, 1'b1, "single_chunk");  // the ones now sit in chunk 0
    endtask

    task automatic test_full_convolution();
        for (int b = 0; b < nti; b++) begin
            for (int a = 0; a < bank_depth; a++) begin
                tbl[b][a] = rand_word();
            end
        end
        load_table();
        wait_frame_end();
        for (int f = 0; f < conv_runs; f++) begin
            run_frame(nti'(rand_bits(nti)), 1'b1, "full_convolution");
        end
    endtask

    task automatic test_table_rewrite();
        for (int f = 0; f < 3; f++) begin
            run_frame(nti'(rand_bits(nti)), 1'b1, "table_rewrite");
        end
        for (int a = 0; a < bank_depth; a++) begin
            write_word(1, a, rand_word());
        end
        wait_frame_end();
        for (int f = 0; f < 5; f++) begin
            run_frame(nti'(rand_bits(nti)), 1'b1, "table_rewrite");
        end
    endtask

    task automatic test_sign_saturation();
        int big_words [nti];
        big_words = '{-1000, -100, 20000, -32768};
        for (int b = 0; b < nti; b++) begin
            for (int a = 0; a < bank_depth; a++) begin
                tbl[b][a] = 0;
            end
            for (int k = 0; k < num_chunks; k++) begin
                tbl[b][k * (2 ** chunk_width)] = big_words[b];
            end
        end
        load_table();
        wait_frame_end();
        for (int f = 0; f < num_chunks + 2; f++) begin
            run_frame('0, 1'b1, "sign_saturation");
        end
        // -400 keeps magnitude 100 while the others clip
        check_value("sign_saturation", 0, '{sign: 1'b1, mag: 8'd255});
        check_value("sign_saturation", 1, '{sign: 1'b1, mag: 8'd100});
        check_value("sign_saturation", 2, '{sign: 1'b0, mag: 8'd255});
    endtask

    initial begin
        rx_bits_i  = '0;
        chan_wr_i  = '0;
        lfsr_state = 32'h2bc2e552;
        @(negedge emu_rst);
        test_reset_state();
        test_single_chunk();
        test_full_convolution();
        test_table_rewrite();
        test_sign_saturation();
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests completed");
        abort_run();
    end

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 3
) (
    output logic emu_clk,
    output logic emu_rst
);
    initial begin
        emu_clk = 1'b0;
        forever begin
            #(period_ns / 2);
            emu_clk = ~emu_clk;
        end
    end

    // reset drops a little after a rising edge, like every other input
    initial begin
        emu_rst = 1'b1;
        repeat (reset_cycles) @(posedge emu_clk);
        #5;
        emu_rst = 1'b0;
    end

endmodule

/* verilog/analog_core_emu.sv */
`timescale 1ns/1ps

module analog_core_emu #(
    parameter int chunk_width = 4,
    parameter int num_chunks  = 4,
    parameter int nti         = 4,
    parameter int out_shift   = 2
) (
    input  logic                             emu_clk,
    input  logic                             emu_rst,
    input  logic [nti-1:0]                   rx_bits_i,
    input  acore_pkg::chan_wr_t              chan_wr_i,
    output logic                             clk_adc_o,
    output acore_pkg::adc_sample_t [nti-1:0] samples_o
);
    acore_pkg::slice_ctl_t                            slice_ctl;
    logic signed [nti-1:0][acore_pkg::step_width-1:0] step_words;

    // counter, bit history and strobes
    frame_sequencer #(
        .chunk_width (chunk_width),
        .num_chunks  (num_chunks),
        .nti         (nti)
    ) i_frame_sequencer (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .rx_bits_i   (rx_bits_i),
        .slice_ctl_o (slice_ctl),
        .clk_adc_o   (clk_adc_o)
    );

    // one bank of step words per slice
    step_table #(
        .chunk_width  (chunk_width),
        .num_chunks   (num_chunks),
        .nti          (nti)
    ) i_step_table (
        .emu_clk      (emu_clk),
        .chan_wr_i    (chan_wr_i),
        .slice_ctl_i  (slice_ctl),
        .step_words_o (step_words)
    );

    for (genvar s = 0; s < nti; s++) begin : g_slice
        emu_slice #(
            .out_shift   (out_shift)
        ) i_emu_slice (
            .emu_clk     (emu_clk),
            .emu_rst     (emu_rst),
            .slice_ctl_i (slice_ctl),
            .step_word_i (step_words[s]),
            .sample_o    (samples_o[s])
        );
    end

endmodule

/* verilog/emu_slice.sv */
`timescale 1ns/1ps

module emu_slice #(
    parameter int out_shift = 2
) (
    input  logic                                 emu_clk,
    input  logic                                 emu_rst,
    input  acore_pkg::slice_ctl_t                slice_ctl_i,
    input  logic signed [acore_pkg::step_width-1:0] step_word_i,
    output acore_pkg::adc_sample_t               sample_o
);
    localparam int sum_w   = acore_pkg::sum_width;
    localparam int step_w  = acore_pkg::step_width;
    localparam int mag_w   = acore_pkg::mag_width;
    localparam int mag_max = (2 ** mag_w) - 1;

    logic                    word_valid_q;  // table word on step_word_i is fresh
    logic signed [sum_w-1:0] acc;
    logic signed [sum_w-1:0] step_ext;
    logic                    sum_sign;
    logic [sum_w-1:0]        sum_abs;
    logic [sum_w-1:0]        sum_shift;
    logic [mag_w-1:0]        sum_mag;
    logic                    load_seen;

    assign step_ext = {{(sum_w - step_w){step_word_i[step_w-1]}}, step_word_i};

    // the table answers one cycle after each read request
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= slice_ctl_i.chunk_valid;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            acc <= '0;
        end else if (word_valid_q) begin
            if (slice_ctl_i.incr_sum) begin
                acc <= acc + step_ext;
            end else begin
                acc <= step_ext;  // first chunk of the frame
            end
        end
    end

    // sign and magnitude of the finished sum
    assign sum_sign  = acc[sum_w-1];
    assign sum_abs   = sum_sign ? (~acc + 1'b1) : acc;
    assign sum_shift = sum_abs >> out_shift;
    assign sum_mag   = (sum_shift > sum_w'(mag_max)) ? mag_w'(mag_max) : mag_w'(sum_shift);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            sample_o <= '0;
        end else if (slice_ctl_i.last_cycle) begin
            sample_o.sign <= sum_sign;
            sample_o.mag  <= sum_mag;  // held for the whole next frame
        end
    end

    // one load per frame, otherwise chunks would be dropped from the sum
    always_ff @(posedge emu_clk) begin
        if (emu_rst || slice_ctl_i.last_cycle) begin
            load_seen <= 1'b0;
        end else if (!slice_ctl_i.incr_sum) begin
            load_seen <= 1'b1;
        end
    end

    a_single_load: assert property (
        @(posedge emu_clk) disable iff (emu_rst) !slice_ctl_i.incr_sum |-> !load_seen
    ) else $error("accumulator loaded twice in one frame");

endmodule

/* verilog/step_table.sv */
`timescale 1ns/1ps

module step_table #(
    parameter int chunk_width = 4,
    parameter int num_chunks  = 4,
    parameter int nti         = 4
) (
    input  logic                                              emu_clk,
    input  acore_pkg::chan_wr_t                               chan_wr_i,
    input  acore_pkg::slice_ctl_t                             slice_ctl_i,
    output logic signed [nti-1:0][acore_pkg::step_width-1:0] step_words_o
);
    // each bank covers every chunk value of every chunk position
    localparam int bank_depth = num_chunks * (2 ** chunk_width);
    localparam int addr_w     = (bank_depth > 1) ? $clog2(bank_depth) : 1;

    logic [acore_pkg::chan_addr_width-1:0] wr_bank;
    logic [addr_w-1:0]                     wr_offs;
    logic [addr_w-1:0]                     rd_addr;

    // write address splits into bank and {chunk_idx, chunk}
    assign wr_bank = acore_pkg::chan_addr_width'(chan_wr_i.waddr / bank_depth);
    assign wr_offs = addr_w'(chan_wr_i.waddr % bank_depth);

    // read address from the sequencer, same layout
    assign rd_addr = addr_w'(slice_ctl_i.chunk_idx * (2 ** chunk_width)
                             + slice_ctl_i.chunk[chunk_width-1:0]);

    for (genvar b = 0; b < nti; b++) begin : g_bank
        logic signed [acore_pkg::step_width-1:0] mem [bank_depth];

        always_ff @(posedge emu_clk) begin
            if (chan_wr_i.we && (wr_bank == b)) begin
                mem[wr_offs] <= chan_wr_i.wdata;
            end
            if (slice_ctl_i.chunk_valid) begin
                step_words_o[b] <= mem[rd_addr];  // word lands one cycle later
            end
        end
    end

    // software must stay inside the banks that exist
    a_waddr_range: assert property (
        @(posedge emu_clk) chan_wr_i.we |-> (chan_wr_i.waddr < nti * bank_depth)
    ) else $error("step table write address %0d beyond %0d banks", chan_wr_i.waddr, nti);

endmodule

/* verilog/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int chunk_width = 4,
    parameter int num_chunks  = 4,
    parameter int nti         = 4
) (
    input  logic                  emu_clk,
    input  logic                  emu_rst,
    input  logic [nti-1:0]        rx_bits_i,
    output acore_pkg::slice_ctl_t slice_ctl_o,
    output logic                  clk_adc_o
);
    localparam int hist_w  = num_chunks * chunk_width;
    localparam int cnt_w   = $clog2(num_chunks + 2);
    localparam int shift_w = (hist_w > 1) ? $clog2(hist_w) : 1;

    // sample clock is low for about half of the frame
    localparam int clock_fall = 2;
    localparam int clock_rise = clock_fall + ((2 + num_chunks) / 2) - 1;

    logic [cnt_w-1:0]       counter;
    logic [hist_w-1:0]      history;
    logic [3:0]             chunk_idx;
    logic [shift_w-1:0]     history_shift;
    logic [chunk_width-1:0] chunk_sel;
    logic                   last_cycle;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            counter <= '0;
        end else if (last_cycle) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // newest bits enter at the top, oldest fall off the bottom
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            history <= '0;
        end else if (last_cycle) begin
            history <= {rx_bits_i, history[hist_w-1:nti]};
        end
    end

    assign last_cycle = (counter == cnt_w'(num_chunks + 1));
    assign chunk_idx  = (counter < cnt_w'(num_chunks)) ? 4'(counter) : 4'd0;

    // chunk 0 is the top field of the history
    assign history_shift = shift_w'((num_chunks - 1 - chunk_idx) * chunk_width);
    assign chunk_sel     = chunk_width'(history >> history_shift);

    always_comb begin
        slice_ctl_o             = '0;
        slice_ctl_o.chunk       = 8'(chunk_sel);
        slice_ctl_o.chunk_idx   = chunk_idx;
        slice_ctl_o.chunk_valid = (counter < cnt_w'(num_chunks));
        slice_ctl_o.incr_sum    = (counter != cnt_w'(1));  // first word loads the sum
        slice_ctl_o.last_cycle  = last_cycle;
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            clk_adc_o <= 1'b1;
        end else begin
            clk_adc_o <= !((counter >= cnt_w'(clock_fall)) && (counter <= cnt_w'(clock_rise)));
        end
    end

    a_counter_range: assert property (
        @(posedge emu_clk) disable iff (emu_rst) counter <= cnt_w'(num_chunks + 1)
    ) else $error("frame counter out of range: %0d", counter);

    a_read_not_last: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
            !(slice_ctl_o.last_cycle && slice_ctl_o.chunk_valid)
    ) else $error("table read requested on the last frame cycle");

endmodule

/* verilog/acore_pkg.sv */
package acore_pkg;

    // fixed word widths of the emulated front end
    localparam int step_width      = 16;  // signed step-response word
    localparam int sum_width       = 20;  // slice accumulator
    localparam int mag_width       = 8;   // output magnitude
    localparam int chan_addr_width = 10;  // {bank, chunk_idx, chunk}

    // software write into the step table
    typedef struct packed {
        logic                       we;
        logic [chan_addr_width-1:0] waddr;
        logic [step_width-1:0]      wdata;
    } chan_wr_t;

    // per-cycle control broadcast by the frame sequencer
    typedef struct packed {
        logic [7:0] chunk;        // low chunk_width bits used
        logic [3:0] chunk_idx;    // low bits used
        logic       chunk_valid;  // table read this cycle
        logic       incr_sum;     // low means load instead of add
        logic       last_cycle;   // end of frame
    } slice_ctl_t;

    // one slice result, sign and magnitude
    typedef struct packed {
        logic                 sign;
        logic [mag_width-1:0] mag;
    } adc_sample_t;

endpackage
